// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f vlog.f --top-module tb_wb_stage \
		-Mdir obj_dir -o sim_wb_stage
	./obj_dir/sim_wb_stage

clean:
	rm -rf obj_dir

// ==== hw/gpr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wb_macros.svh"

// 32 x 64 general registers, x0 hardwired to zero
module gpr_file (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              we,
    input  wb_pkg::reg_idx_t  waddr,
    input  wb_pkg::xlen_t     wdata,
    input  wb_pkg::reg_idx_t  raddr,
    output wb_pkg::xlen_t     rdata,
    input  wb_pkg::reg_idx_t  dbg_raddr,
    output wb_pkg::xlen_t     dbg_rdata
);

    import wb_pkg::*;

    xlen_t regs [`WB_REG_DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `WB_REG_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin  // x0 is read only
            regs[waddr] <= wdata;
        end
    end

    // store base operand
    assign rdata = regs[raddr];

    // debug view, new value shows the cycle after the write
    assign dbg_rdata = regs[dbg_raddr];

endmodule

`default_nettype wire

// ==== hw/store_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

// one store in flight at a time
// write request phase, then write response phase, then a one cycle done
module store_issue (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  wb_pkg::xlen_t       base_val,
    input  wb_pkg::imm_t        imm,
    input  wb_pkg::xlen_t       data,
    input  wb_pkg::byte_mask_t  wmask,
    output logic                idle,
    output logic                wr_valid,
    output wb_pkg::mem_wr_t     wr_req,
    input  logic                wr_ready,
    input  logic                b_valid,
    output logic                b_ready,
    output logic                store_done
);

    import wb_pkg::*;

    store_state_t state;
    store_state_t state_nxt;
    xlen_t        addr_calc;

    // base + sign-extended offset
    assign addr_calc = base_val + xlen_t'(signed'(imm));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    state_nxt = ST_WRITE;
                end
            end
            ST_WRITE: begin
                if (wr_ready) begin  // write handshake
                    state_nxt = ST_WRESP;
                end
            end
            ST_WRESP: begin
                if (b_valid) begin   // response handshake
                    state_nxt = ST_DONE;
                end
            end
            ST_DONE: begin
                state_nxt = ST_IDLE;
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    // request payload, held from acceptance until done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_req <= '0;
        end else if ((state == ST_IDLE) && start) begin
            wr_req.addr  <= addr_calc;
            wr_req.data  <= data;
            wr_req.wmask <= wmask;
        end else if (state == ST_DONE) begin
            wr_req <= '0;
        end
    end

    assign idle       = (state == ST_IDLE);
    assign wr_valid   = (state == ST_WRITE);
    assign b_ready    = (state == ST_WRESP);
    assign store_done = (state == ST_DONE);

endmodule

`default_nettype wire

// ==== hw/wb_ctrl_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wb_macros.svh"

// halt flag and retire counter beside the stage
module wb_ctrl_regs (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  accept,
    input  wb_pkg::op_kind_t      accept_kind,
    input  logic                  halt_clr,
    output logic                  halted,
    output logic [`WB_CNT_W-1:0]  retired
);

    import wb_pkg::*;

    logic halt_set;

    assign halt_set = accept && (accept_kind == OP_EBREAK);

    // ebreak wins over a clear in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halted <= 1'b0;
        end else if (halt_set) begin
            halted <= 1'b1;
        end else if (halt_clr) begin
            halted <= 1'b0;
        end
    end

    // counts every accepted op, stores included at acceptance
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retired <= '0;
        end else if (accept) begin
            retired <= retired + `WB_CNT_W'(1);  // wraps
        end
    end

endmodule

`default_nettype wire

// ==== hw/wb_macros.svh ====
`ifndef WB_MACROS_SVH
`define WB_MACROS_SVH

// datapath width of the core
`define WB_XLEN 64

// general register file geometry
`define WB_REG_AW 5
`define WB_REG_DEPTH 32

// one enable per byte of a data word
`define WB_MASK_W 8

// retired instruction counter, wraps
`define WB_CNT_W 32

`endif

// ==== hw/wb_pkg.sv ====
`default_nettype none

`include "wb_macros.svh"

package wb_pkg;

    typedef logic [`WB_XLEN-1:0]   xlen_t;
    typedef logic [`WB_REG_AW-1:0] reg_idx_t;
    typedef logic [`WB_MASK_W-1:0] byte_mask_t;
    typedef logic [31:0]           imm_t;       // store offset, sign-extended when added

    // result extension applied before writeback
    typedef enum logic [1:0] {
        EXT_FULL   = 2'd0,  // all 64 bits
        EXT_W_SIGN = 2'd1,  // lw, addw and friends
        EXT_W_ZERO = 2'd2,  // lwu
        EXT_H_SIGN = 2'd3   // lh
    } ext_mode_t;

    typedef enum logic [1:0] {
        OP_REG    = 2'd0,
        OP_STORE  = 2'd1,
        OP_EBREAK = 2'd2
    } op_kind_t;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_WRITE = 2'd1,
        ST_WRESP = 2'd2,
        ST_DONE  = 2'd3
    } store_state_t;

    // one retiring instruction
    typedef struct packed {
        op_kind_t   kind;
        reg_idx_t   rd;
        ext_mode_t  ext;
        logic       from_mem;   // take mem_res instead of ex_res
        xlen_t      ex_res;
        xlen_t      mem_res;
        reg_idx_t   base;       // store base register
        imm_t       imm;
        byte_mask_t wmask;
    } wb_op_t;

    typedef struct packed {
        xlen_t      addr;
        xlen_t      data;
        byte_mask_t wmask;
    } mem_wr_t;

endpackage

`default_nettype wire

// ==== hw/wb_result_sel.sv ====
`timescale 1ns/1ps
`default_nettype none

// result mux plus sign or zero extension
// feeds both the register write and the store data
module wb_result_sel (
    input  wb_pkg::wb_op_t op,
    output wb_pkg::xlen_t  wdata
);

    import wb_pkg::*;

    xlen_t raw;

    // load data comes back through the memory stage
    always_comb begin
        if (op.from_mem) begin
            raw = op.mem_res;
        end else begin
            raw = op.ex_res;
        end
    end

    always_comb begin
        case (op.ext)
            EXT_FULL: begin
                wdata = raw;
            end
            EXT_W_SIGN: begin
                wdata = {{32{raw[31]}}, raw[31:0]};
            end
            EXT_W_ZERO: begin
                wdata = {32'd0, raw[31:0]};
            end
            EXT_H_SIGN: begin
                wdata = {{48{raw[15]}}, raw[15:0]};
            end
            default: begin
                wdata = raw;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/wb_stage_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wb_macros.svh"

// writeback stage, one retiring op per handshake
module wb_stage_top (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  in_valid,
    output logic                  in_ready,
    input  wb_pkg::wb_op_t        in_op,

    output logic                  wr_valid,
    output wb_pkg::mem_wr_t       wr_req,
    input  logic                  wr_ready,
    input  logic                  b_valid,
    output logic                  b_ready,
    output logic                  store_done,

    input  logic                  halt_clr,
    output logic                  halted,
    output logic [`WB_CNT_W-1:0]  retired,

    input  wb_pkg::reg_idx_t      dbg_raddr,
    output wb_pkg::xlen_t         dbg_rdata
);

    import wb_pkg::*;

    logic  accept;
    logic  reg_we;
    logic  st_start;
    logic  st_idle;
    xlen_t res_val;
    xlen_t base_val;

    // stalled while halted or while a store is outstanding
    assign in_ready = !halted && st_idle;
    assign accept   = in_valid && in_ready;
    assign reg_we   = accept && (in_op.kind == OP_REG);
    assign st_start = accept && (in_op.kind == OP_STORE);

    wb_result_sel u_sel (
        .op    (in_op),
        .wdata (res_val)
    );

    gpr_file u_gpr (
        .clk       (clk),
        .rst_n     (rst_n),
        .we        (reg_we),
        .waddr     (in_op.rd),
        .wdata     (res_val),
        .raddr     (in_op.base),
        .rdata     (base_val),
        .dbg_raddr (dbg_raddr),
        .dbg_rdata (dbg_rdata)
    );

    store_issue u_store (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (st_start),
        .base_val   (base_val),
        .imm        (in_op.imm),
        .data       (res_val),
        .wmask      (in_op.wmask),
        .idle       (st_idle),
        .wr_valid   (wr_valid),
        .wr_req     (wr_req),
        .wr_ready   (wr_ready),
        .b_valid    (b_valid),
        .b_ready    (b_ready),
        .store_done (store_done)
    );

    wb_ctrl_regs u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .accept      (accept),
        .accept_kind (in_op.kind),
        .halt_clr    (halt_clr),
        .halted      (halted),
        .retired     (retired)
    );

endmodule

`default_nettype wire

// ==== tests/tb_bus_responder.sv ====
`timescale 1ns/1ps
`default_nettype none

// write-only memory bus slave with random stalls on both channels
module tb_bus_responder #(
    parameter logic [31:0] SEED = 32'ha9882566
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            wr_valid,
    input  wb_pkg::mem_wr_t wr_req,
    output logic            wr_ready,
    output logic            b_valid,
    input  logic            b_ready,
    output logic [31:0]     wr_count,
    output logic [31:0]     b_count,
    output wb_pkg::mem_wr_t last_wr
);

    import wb_pkg::*;

    integer seed;

    // ready and response change on the falling edge only
    initial begin
        seed     = SEED;
        wr_ready = 1'b0;
        b_valid  = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst_n) begin
                wr_ready = 1'b0;
                b_valid  = 1'b0;
            end else begin
                wr_ready = wr_valid && (($random(seed) & 3) == 0);  // about 1 in 4
                b_valid  = b_ready && (($random(seed) & 1) == 0);
            end
        end
    end

    // log of completed bus writes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_count <= '0;
            b_count  <= '0;
            last_wr  <= '0;
        end else begin
            if (wr_valid && wr_ready) begin
                wr_count <= wr_count + 32'd1;
                last_wr  <= wr_req;
            end
            if (b_valid && b_ready) begin
                b_count <= b_count + 32'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_wb_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wb_macros.svh"

module tb_wb_stage;

    import wb_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int TIMEOUT_CYCLES = 200;
    localparam logic [31:0] SEED = 32'ha9882566;

    logic                 clk;
    logic                 rst_n;
    logic                 in_valid;
    logic                 in_ready;
    wb_op_t               in_op;
    logic                 wr_valid;
    mem_wr_t              wr_req;
    logic                 wr_ready;
    logic                 b_valid;
    logic                 b_ready;
    logic                 store_done;
    logic                 halt_clr;
    logic                 halted;
    logic [`WB_CNT_W-1:0] retired;
    reg_idx_t             dbg_raddr;
    xlen_t                dbg_rdata;
    logic [31:0]          wr_count;
    logic [31:0]          b_count;
    mem_wr_t              last_wr;

    integer               seed;
    xlen_t                model_regs [$];  // reference register file
    logic [`WB_CNT_W-1:0] accepted_cnt;
    logic [31:0]          stores_sent;
    logic [31:0]          done_cnt;
    logic                 store_busy;
    logic                 wait_wr;         // write request stalled last edge
    mem_wr_t              held_req;
    wb_op_t               op;
    xlen_t                exp_addr;
    xlen_t                exp_data;

    wb_stage_top DUT (
        .clk(clk), .rst_n(rst_n),
        .in_valid(in_valid), .in_ready(in_ready), .in_op(in_op),
        .wr_valid(wr_valid), .wr_req(wr_req), .wr_ready(wr_ready),
        .b_valid(b_valid), .b_ready(b_ready), .store_done(store_done),
        .halt_clr(halt_clr), .halted(halted), .retired(retired),
        .dbg_raddr(dbg_raddr), .dbg_rdata(dbg_rdata)
    );

    tb_bus_responder #(.SEED(SEED)) u_resp (
        .clk(clk), .rst_n(rst_n),
        .wr_valid(wr_valid), .wr_req(wr_req), .wr_ready(wr_ready),
        .b_valid(b_valid), .b_ready(b_ready),
        .wr_count(wr_count), .b_count(b_count), .last_wr(last_wr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic expect_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        assert (got === exp) else report_mismatch(name, got, exp);
    endtask

    // result as the extension rules describe it
    function automatic xlen_t extended_result(input wb_op_t o);
        xlen_t raw;
        raw = o.from_mem ? o.mem_res : o.ex_res;
        case (o.ext)
            EXT_W_SIGN: return xlen_t'($signed(raw[31:0]));
            EXT_W_ZERO: return xlen_t'(raw[31:0]);
            EXT_H_SIGN: return xlen_t'($signed(raw[15:0]));
            default:    return raw;
        endcase
    endfunction

    function automatic wb_op_t random_op(input op_kind_t kind, input ext_mode_t ext,
                                         input logic from_mem);
        wb_op_t o;
        o.kind     = kind;
        o.rd       = reg_idx_t'($random(seed));
        o.ext      = ext;
        o.from_mem = from_mem;
        o.ex_res   = {$random(seed), $random(seed)};
        o.mem_res  = {$random(seed), $random(seed)};
        o.base     = reg_idx_t'($random(seed));
        o.imm      = imm_t'($random(seed));
        o.wmask    = byte_mask_t'($random(seed));
        return o;
    endfunction

    // starts and ends just after a falling edge
    task automatic send_op(input wb_op_t o);
        int waited;
        waited   = 0;
        in_op    = o;
        in_valid = 1'b1;
        while (!in_ready) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) abort_run("timeout waiting for in_ready");
        end
        @(negedge clk);  // accepted at the rising edge in between
        in_valid = 1'b0;
        accepted_cnt = accepted_cnt + `WB_CNT_W'(1);
        if (o.kind == OP_REG && o.rd != '0) model_regs[o.rd] = extended_result(o);
        if (o.kind == OP_STORE) stores_sent = stores_sent + 32'd1;
    endtask

    task automatic check_reg(input reg_idx_t idx);
        dbg_raddr = idx;
        #(CLK_PERIOD/4);
        expect_value("dbg_rdata", 64'(dbg_rdata), model_regs[idx]);
        @(negedge clk);
    endtask

    task automatic wait_store_done();
        int waited;
        waited = 0;
        while (!store_done) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) abort_run("timeout waiting for store_done");
        end
    endtask

    // bus and handshake watch, sampled on the rising edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (store_busy) begin
                assert (!in_ready) else abort_run("in_ready high during a store");
            end
            if (wait_wr) begin
                expect_value("wr_valid", 64'(wr_valid), 64'd1);
                expect_value("wr_req.addr", wr_req.addr, held_req.addr);
                expect_value("wr_req.data", wr_req.data, held_req.data);
                expect_value("wr_req.wmask", 64'(wr_req.wmask), 64'(held_req.wmask));
            end
            if (store_done) done_cnt = done_cnt + 32'd1;
            if (in_valid && in_ready && in_op.kind == OP_STORE) begin
                store_busy = 1'b1;
            end else if (store_done) begin
                store_busy = 1'b0;
            end
            wait_wr  = wr_valid && !wr_ready;
            held_req = wr_req;
        end
    end

    initial begin
        seed         = SEED;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_op        = '0;
        halt_clr     = 1'b0;
        dbg_raddr    = '0;
        accepted_cnt = '0;
        stores_sent  = '0;
        done_cnt     = '0;
        store_busy   = 1'b0;
        wait_wr      = 1'b0;
        held_req     = '0;
        for (int i = 0; i < `WB_REG_DEPTH; i++) model_regs.push_back('0);
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // reset state
        expect_value("wr_valid", 64'(wr_valid), 64'd0);
        expect_value("b_ready", 64'(b_ready), 64'd0);
        expect_value("store_done", 64'(store_done), 64'd0);
        expect_value("halted", 64'(halted), 64'd0);
        expect_value("in_ready", 64'(in_ready), 64'd1);
        expect_value("retired", 64'(retired), 64'd0);
        for (int i = 0; i < `WB_REG_DEPTH; i++) check_reg(reg_idx_t'(i));

        // every extension mode from both result sources
        for (int r = 0; r < 4; r++) begin
            for (int e = 0; e < 4; e++) begin
                for (int m = 0; m < 2; m++) begin
                    op = random_op(OP_REG, ext_mode_t'(e[1:0]), m[0]);
                    send_op(op);
                    check_reg(op.rd);
                end
            end
        end

        // writes to x0 are dropped
        repeat (3) begin
            op    = random_op(OP_REG, EXT_FULL, 1'b0);
            op.rd = '0;
            send_op(op);
            check_reg('0);
        end

        // stores against the bus responder
        for (int i = 0; i < 6; i++) begin
            op       = random_op(OP_STORE, ext_mode_t'(i[1:0]), i[0]);
            exp_addr = model_regs[op.base] + xlen_t'($signed(op.imm));
            exp_data = extended_result(op);
            send_op(op);
            wait_store_done();
            expect_value("last_wr.addr", last_wr.addr, exp_addr);
            expect_value("last_wr.data", last_wr.data, exp_data);
            expect_value("last_wr.wmask", 64'(last_wr.wmask), 64'(op.wmask));
            expect_value("wr_count", 64'(wr_count), 64'(stores_sent));
            @(negedge clk);
            expect_value("done_cnt", 64'(done_cnt), 64'(stores_sent));
            expect_value("b_count", 64'(b_count), 64'(stores_sent));
            expect_value("wr_req.addr", wr_req.addr, 64'd0);  // cleared after done
            expect_value("wr_req.data", wr_req.data, 64'd0);
            expect_value("wr_req.wmask", 64'(wr_req.wmask), 64'd0);
        end

        // register op offered while a store is still in flight
        op = random_op(OP_STORE, EXT_FULL, 1'b0);
        send_op(op);
        op = random_op(OP_REG, EXT_W_SIGN, 1'b1);
        send_op(op);
        check_reg(op.rd);
        expect_value("done_cnt", 64'(done_cnt), 64'(stores_sent));

        // ebreak holds off new ops until halt_clr
        op = random_op(OP_EBREAK, EXT_FULL, 1'b0);
        send_op(op);
        expect_value("halted", 64'(halted), 64'd1);
        expect_value("in_ready", 64'(in_ready), 64'd0);
        op       = random_op(OP_REG, EXT_H_SIGN, 1'b0);
        in_op    = op;
        in_valid = 1'b1;
        repeat (5) begin
            @(negedge clk);
            expect_value("in_ready", 64'(in_ready), 64'd0);
            expect_value("retired", 64'(retired), 64'(accepted_cnt));
        end
        halt_clr = 1'b1;
        @(negedge clk);
        halt_clr = 1'b0;
        expect_value("halted", 64'(halted), 64'd0);
        send_op(op);
        check_reg(op.rd);

        expect_value("retired", 64'(retired), 64'(accepted_cnt));
        expect_value("done_cnt", 64'(done_cnt), 64'(stores_sent));
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hw
hw/wb_pkg.sv
hw/wb_result_sel.sv
hw/gpr_file.sv
hw/store_issue.sv
hw/wb_ctrl_regs.sv
hw/wb_stage_top.sv
tests/tb_bus_responder.sv
tests/tb_wb_stage.sv
